/* verilog.f */
+incdir+hdl
hdl/tpl_dac_pkg.sv
hdl/up_axi_slave.sv
hdl/up_dac_common_regs.sv
hdl/up_dac_channel_regs.sv
hdl/up_tpl_profile_regs.sv
hdl/tpl_dac_regmap.sv
bench/tpl_dac_regmap_asserts.sv
bench/tpl_dac_regmap_tb.sv

/* bench/tpl_dac_regmap_tb.sv */
// Table-driven testbench of the DAC register map over AXI4-Lite, run as the simulation top
`timescale 1ns/100ps
`include "tpl_dac_params.svh"

module tpl_dac_regmap_tb;

  import tpl_dac_pkg::*;

  localparam logic [1:0] OP_WR = 2'd0;
  localparam logic [1:0] OP_RD = 2'd1;
  localparam logic [1:0] OP_DUNF = 2'd2;
  localparam logic [1:0] OP_OUT = 2'd3;
  // Output selectors, carried in the address column of OP_OUT rows
  localparam logic [11:0] SEL_RST = 12'd0;
  localparam logic [11:0] SEL_FORMAT = 12'd1;
  localparam logic [11:0] SEL_SYNC_CNT = 12'd2;
  localparam logic [11:0] SEL_PROFILE = 12'd3;
  localparam logic [11:0] SEL_SYNC = 12'd4;
  localparam int NUM_CH = `TPL_DAC_NUM_CHANNELS;

  typedef struct packed {
    logic [1:0]  op;
    logic [11:0] addr;
    up_data_t    data;
    up_data_t    exp;
  } entry_t;

  logic up_clk = 1'b0;
  logic up_rstn;
  axil_req_t s_axi;
  axil_rsp_t s_axi_rsp;
  logic dac_dunf;
  logic dac_rst;
  logic dac_sync;
  logic dac_dds_format;
  dac_chan_cfg_t dac_chan_cfg [`TPL_DAC_NUM_CHANNELS];
  jesd_params_t jesd_profile [`TPL_DAC_NUM_PROFILES];
  profile_sel_t up_profile_sel;

  entry_t stim [$];
  up_data_t shadow [NUM_CH][5];
  logic [31:0] rng = 32'hfda1;
  int sync_cnt = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  tpl_dac_regmap tpl_dac_regmap_i (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .s_axi          (s_axi),
    .s_axi_rsp      (s_axi_rsp),
    .dac_dunf       (dac_dunf),
    .dac_rst        (dac_rst),
    .dac_sync       (dac_sync),
    .dac_dds_format (dac_dds_format),
    .dac_chan_cfg   (dac_chan_cfg),
    .jesd_profile   (jesd_profile),
    .up_profile_sel (up_profile_sel)
  );

  always #5 up_clk = ~up_clk;

  always @(posedge up_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run still busy after %0d cycles", cycle_cnt);
      $display("sim failed");
      $fatal(1);
    end
  end

  // One count per cycle of dac_sync high
  always @(negedge up_clk) begin
    if (up_rstn && dac_sync) sync_cnt <= sync_cnt + 1;
  end

  // ******************************
  // Helpers
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [11:0] chan_addr(input int ch, input int off);
    return 12'h400 + 12'(ch * 64 + off * 4);
  endfunction

  function automatic dac_chan_cfg_t cfg_from_shadow(input int c);
    dac_chan_cfg_t cfg;
    cfg.dds_scale_0 = shadow[c][0][15:0];
    cfg.dds_scale_1 = shadow[c][0][31:16];
    cfg.dds_init_0 = shadow[c][1][15:0];
    cfg.dds_incr_0 = shadow[c][1][31:16];
    cfg.dds_init_1 = shadow[c][2][15:0];
    cfg.dds_incr_1 = shadow[c][2][31:16];
    cfg.pat_data_0 = shadow[c][3][15:0];
    cfg.pat_data_1 = shadow[c][3][31:16];
    cfg.data_sel = shadow[c][4][3:0];
    return cfg;
  endfunction

  task automatic check_value(input string name, input logic [131:0] got,
                             input logic [131:0] exp);
    assert (got === exp) else begin
      $display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, got);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic add_entry(input logic [1:0] op, input logic [11:0] addr,
                           input up_data_t data, input up_data_t exp);
    stim.push_back({op, addr, data, exp});
  endtask

  // ******************************
  // AXI4-Lite master, bready and rready stay high
  task automatic axi_write(input logic [11:0] addr, input up_data_t data,
                           output logic [1:0] resp);
    @(posedge up_clk);
    #1;
    s_axi.awvalid = 1'b1;
    s_axi.awaddr = addr;
    s_axi.wvalid = 1'b1;
    s_axi.wdata = data;
    s_axi.wstrb = 4'hf;
    @(negedge up_clk);
    while (!(s_axi_rsp.awready && s_axi_rsp.wready)) @(negedge up_clk);
    @(posedge up_clk);
    #1;
    s_axi.awvalid = 1'b0;
    s_axi.wvalid = 1'b0;
    while (!s_axi_rsp.bvalid) @(negedge up_clk);
    resp = s_axi_rsp.bresp;
    @(posedge up_clk);
    #1;
  endtask

  task automatic axi_read(input logic [11:0] addr, output up_data_t data,
                          output logic [1:0] resp);
    @(posedge up_clk);
    #1;
    s_axi.arvalid = 1'b1;
    s_axi.araddr = addr;
    @(negedge up_clk);
    while (!s_axi_rsp.arready) @(negedge up_clk);
    @(posedge up_clk);
    #1;
    s_axi.arvalid = 1'b0;
    while (!s_axi_rsp.rvalid) @(negedge up_clk);
    data = s_axi_rsp.rdata;
    resp = s_axi_rsp.rresp;
    @(posedge up_clk);
    #1;
  endtask

  task automatic pulse_dunf();
    @(posedge up_clk);
    #1;
    dac_dunf = 1'b1;
    @(posedge up_clk);
    #1;
    dac_dunf = 1'b0;
  endtask

  task automatic check_output(input logic [11:0] sel, input up_data_t exp);
    case (sel)
      SEL_RST: check_value("dac_rst", dac_rst, exp);
      SEL_FORMAT: check_value("dac_dds_format", dac_dds_format, exp);
      SEL_SYNC_CNT: check_value("dac_sync high cycles", sync_cnt, exp);
      SEL_PROFILE: check_value("up_profile_sel", up_profile_sel, exp);
      default: check_value("dac_sync", dac_sync, exp);
    endcase
  endtask

  // Shadow of the channel words, as the channel register layout stores them
  task automatic note_write(input logic [11:0] addr, input up_data_t data);
    if (addr[11:10] == 2'(`TPL_DAC_REGION_CHANNEL) && addr[9:6] < NUM_CH && addr[5:2] <= 4) begin
      shadow[addr[9:6]][addr[5:2]] = (addr[5:2] == 4) ? (data & 32'hf) : data;
    end
  endtask

  task automatic compare_cfgs();
    for (int c = 0; c < NUM_CH; c++) begin
      check_value($sformatf("dac_chan_cfg[%0d]", c), dac_chan_cfg[c], cfg_from_shadow(c));
    end
  endtask

  // ******************************
  // Stimulus table
  task automatic build_table();
    up_data_t back [NUM_CH][5];
    jesd_params_t p0;
    jesd_params_t p1;
    p0 = jesd_profile[0];
    p1 = jesd_profile[1];
    // Reset state and identification
    add_entry(OP_OUT, SEL_RST, 0, 1);
    add_entry(OP_OUT, SEL_SYNC, 0, 0);
    add_entry(OP_OUT, SEL_PROFILE, 0, 0);
    add_entry(OP_OUT, SEL_FORMAT, 0, 0);
    add_entry(OP_RD, 12'h000, 0, `TPL_DAC_VERSION);
    add_entry(OP_RD, 12'h004, 0, `TPL_DAC_CORE_ID);
    add_entry(OP_RD, 12'h04c, 0, `TPL_DAC_NUM_CHANNELS);
    add_entry(OP_RD, 12'h800, 0, `TPL_DAC_NUM_PROFILES);
    rng = xorshift(rng);
    add_entry(OP_WR, 12'h008, rng, 0);
    add_entry(OP_RD, 12'h008, 0, rng);
    // All channel words first, then read them all back
    for (int c = 0; c < NUM_CH; c++) begin
      for (int o = 0; o < 5; o++) begin
        rng = xorshift(rng);
        back[c][o] = (o == 4) ? (rng & 32'hf) : rng;
        add_entry(OP_WR, chan_addr(c, o), rng, 0);
      end
    end
    for (int c = 0; c < NUM_CH; c++) begin
      for (int o = 0; o < 5; o++) add_entry(OP_RD, chan_addr(c, o), 0, back[c][o]);
    end
    // Data path release, format and sync
    add_entry(OP_WR, 12'h040, 32'h1, 0);
    add_entry(OP_OUT, SEL_RST, 0, 0);
    add_entry(OP_RD, 12'h040, 0, 32'h1);
    add_entry(OP_WR, 12'h044, 32'h10, 0);
    add_entry(OP_OUT, SEL_FORMAT, 0, 1);
    add_entry(OP_OUT, SEL_SYNC_CNT, 0, 0);
    add_entry(OP_WR, 12'h044, 32'h11, 0);
    add_entry(OP_OUT, SEL_SYNC_CNT, 0, 1);
    add_entry(OP_OUT, SEL_SYNC, 0, 0);
    add_entry(OP_RD, 12'h044, 0, 32'h10);
    // Sticky underflow
    add_entry(OP_RD, 12'h048, 0, 32'h0);
    add_entry(OP_DUNF, 12'h000, 0, 0);
    add_entry(OP_RD, 12'h048, 0, 32'h1);
    add_entry(OP_RD, 12'h048, 0, 32'h1);
    add_entry(OP_WR, 12'h048, 32'h1, 0);
    add_entry(OP_RD, 12'h048, 0, 32'h0);
    // Profile select and framer read-back
    add_entry(OP_RD, 12'h804, 0, 32'h0);
    add_entry(OP_RD, 12'h808, 0, {p0.f, p0.s, p0.l, p0.m});
    add_entry(OP_WR, 12'h804, 32'h1, 0);
    add_entry(OP_OUT, SEL_PROFILE, 0, 1);
    add_entry(OP_RD, 12'h808, 0, {p1.f, p1.s, p1.l, p1.m});
    add_entry(OP_RD, 12'h80c, 0, {16'd0, p1.np, p1.n});
    add_entry(OP_WR, 12'h804, 32'h2, 0);
    add_entry(OP_OUT, SEL_PROFILE, 0, 1);
    add_entry(OP_RD, 12'h804, 0, 32'h1);
    // Unclaimed region, answered by the slave timeout
    add_entry(OP_RD, 12'hc00, 0, 32'h0);
  endtask

  initial begin
    entry_t e;
    up_data_t rdata;
    logic [1:0] resp;
    s_axi = '0;
    s_axi.bready = 1'b1;
    s_axi.rready = 1'b1;
    dac_dunf = 1'b0;
    up_rstn = 1'b0;
    jesd_profile[0] = '{m: 8'd2, l: 8'd4, s: 8'd1, f: 8'd1, n: 8'd16, np: 8'd16};
    jesd_profile[1] = '{m: 8'd4, l: 8'd8, s: 8'd2, f: 8'd3, n: 8'd14, np: 8'd12};
    foreach (shadow[c, o]) shadow[c][o] = '0;
    build_table();
    cycle_limit = 20 * stim.size() + 100;
    repeat (5) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;
    compare_cfgs();
    foreach (stim[i]) begin
      e = stim[i];
      case (e.op)
        OP_WR: begin
          axi_write(e.addr, e.data, resp);
          check_value($sformatf("bresp@%03h", e.addr), resp, e.exp);
          note_write(e.addr, e.data);
          compare_cfgs();
        end
        OP_RD: begin
          axi_read(e.addr, rdata, resp);
          check_value($sformatf("rdata@%03h", e.addr), rdata, e.exp);
          check_value($sformatf("rresp@%03h", e.addr), resp, 2'b00);
        end
        OP_DUNF: pulse_dunf();
        default: check_output(e.addr, e.exp);
      endcase
    end
    $display("sim passed");
    $finish;
  end

endmodule

/* bench/tpl_dac_regmap_asserts.sv */
// Protocol checks on the AXI4-Lite slave and its up-bus requests, bound into up_axi_slave
`timescale 1ns/100ps

module tpl_dac_regmap_asserts (
  input logic                    up_clk,
  input logic                    up_rstn,
  input tpl_dac_pkg::axil_req_t  s_axi,
  input tpl_dac_pkg::axil_rsp_t  s_axi_rsp,
  input tpl_dac_pkg::up_wr_req_t up_wr,
  input tpl_dac_pkg::up_rd_req_t up_rd
);

  // Responses stay up until the master takes them
  bvalid_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_rsp.bvalid && !s_axi.bready |=> s_axi_rsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge up_clk) disable iff (!up_rstn)
    s_axi_rsp.rvalid && !s_axi.rready |=> s_axi_rsp.rvalid)
    else $error("rvalid dropped before rready");

  // Up-bus requests are single-cycle pulses
  wreq_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wr.wreq |=> !up_wr.wreq)
    else $error("wreq held longer than one cycle");

  rreq_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rd.rreq |=> !up_rd.rreq)
    else $error("rreq held longer than one cycle");

  // First cycle out of reset
  reset_quiet: assert property (@(posedge up_clk)
    $rose(up_rstn) |-> !s_axi_rsp.bvalid && !s_axi_rsp.rvalid)
    else $error("valid output high right after reset");

endmodule

bind up_axi_slave tpl_dac_regmap_asserts tpl_dac_regmap_asserts_i (.*);

/* hdl/tpl_dac_regmap.sv */
// Top of the DAC register map: AXI4-Lite bridge plus common, channel and profile blocks
`timescale 1ns/100ps
`include "tpl_dac_params.svh"

module tpl_dac_regmap (
  input  logic                       up_clk,
  input  logic                       up_rstn,
  input  tpl_dac_pkg::axil_req_t     s_axi,
  output tpl_dac_pkg::axil_rsp_t     s_axi_rsp,
  input  logic                       dac_dunf,
  output logic                       dac_rst,
  output logic                       dac_sync,
  output logic                       dac_dds_format,
  output tpl_dac_pkg::dac_chan_cfg_t dac_chan_cfg [`TPL_DAC_NUM_CHANNELS],
  input  tpl_dac_pkg::jesd_params_t  jesd_profile [`TPL_DAC_NUM_PROFILES],
  output tpl_dac_pkg::profile_sel_t  up_profile_sel
);

  import tpl_dac_pkg::*;

  // Common block, one per channel, then the profile block
  localparam int NUM_BLOCKS = `TPL_DAC_NUM_CHANNELS + 2;

  up_wr_req_t up_wr;
  up_rd_req_t up_rd;
  up_rsp_t blk_rsp [NUM_BLOCKS];
  up_rsp_t rsp_all;
  up_rsp_t rsp_q;

  up_axi_slave up_axi_slave_i (
    .up_clk    (up_clk),
    .up_rstn   (up_rstn),
    .s_axi     (s_axi),
    .s_axi_rsp (s_axi_rsp),
    .up_wr     (up_wr),
    .up_rd     (up_rd),
    .up_rsp    (rsp_q)
  );

  up_dac_common_regs up_dac_common_regs_i (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_wr          (up_wr),
    .up_rd          (up_rd),
    .dac_dunf       (dac_dunf),
    .up_rsp         (blk_rsp[0]),
    .dac_rst        (dac_rst),
    .dac_sync       (dac_sync),
    .dac_dds_format (dac_dds_format)
  );

  for (genvar i = 0; i < `TPL_DAC_NUM_CHANNELS; i++) begin : g_channel
    up_dac_channel_regs #(
      .CHANNEL_ID (i)
    ) up_dac_channel_regs_i (
      .up_clk       (up_clk),
      .up_rstn      (up_rstn),
      .up_wr        (up_wr),
      .up_rd        (up_rd),
      .up_rsp       (blk_rsp[i+1]),
      .dac_chan_cfg (dac_chan_cfg[i])
    );
  end

  up_tpl_profile_regs up_tpl_profile_regs_i (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .up_wr          (up_wr),
    .up_rd          (up_rd),
    .jesd_profile   (jesd_profile),
    .up_rsp         (blk_rsp[NUM_BLOCKS-1]),
    .up_profile_sel (up_profile_sel)
  );

  // ******************************
  // Idle blocks return zero, so a plain OR merges them
  always_comb begin
    rsp_all = '0;
    for (int n = 0; n < NUM_BLOCKS; n++) begin
      rsp_all = rsp_all | blk_rsp[n];
    end
  end

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      rsp_q <= '0;
    end else begin
      rsp_q <= rsp_all;
    end
  end

endmodule

/* hdl/up_tpl_profile_regs.sv */
// Transport-layer registers: JESD profile select and read-back of framer parameters
`timescale 1ns/100ps
`include "tpl_dac_params.svh"

module up_tpl_profile_regs (
  input  logic                      up_clk,
  input  logic                      up_rstn,
  input  tpl_dac_pkg::up_wr_req_t   up_wr,
  input  tpl_dac_pkg::up_rd_req_t   up_rd,
  input  tpl_dac_pkg::jesd_params_t jesd_profile [`TPL_DAC_NUM_PROFILES],
  output tpl_dac_pkg::up_rsp_t      up_rsp,
  output tpl_dac_pkg::profile_sel_t up_profile_sel
);

  import tpl_dac_pkg::*;

  logic wr_sel;
  logic rd_sel;
  profile_sel_t sel_q;
  jesd_params_t prof;
  logic wack_q;
  logic rack_q;
  up_data_t rdata_q;
  up_data_t rd_word;

  assign wr_sel = up_wr.wreq && (up_wr.waddr[9:8] == 2'(`TPL_DAC_REGION_TPL));
  assign rd_sel = up_rd.rreq && (up_rd.raddr[9:8] == 2'(`TPL_DAC_REGION_TPL));

  // Out-of-range selections are acked and dropped
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      sel_q <= '0;
    end else if (wr_sel && (up_wr.waddr[7:0] == 8'h01) &&
                 (up_wr.wdata < 32'(`TPL_DAC_NUM_PROFILES))) begin
      sel_q <= up_wr.wdata[$bits(profile_sel_t)-1:0];
    end
  end

  assign prof = jesd_profile[sel_q];

  always_comb begin
    case (up_rd.raddr[7:0])
      8'h00: rd_word = 32'(`TPL_DAC_NUM_PROFILES);
      8'h01: rd_word = 32'(sel_q);
      8'h02: rd_word = {prof.f, prof.s, prof.l, prof.m};
      8'h03: rd_word = {16'd0, prof.np, prof.n};
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      wack_q <= 1'b0;
      rack_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      wack_q <= wr_sel;
      rack_q <= rd_sel;
      rdata_q <= rd_sel ? rd_word : '0;
    end
  end

  assign up_rsp = '{wack: wack_q, rack: rack_q, rdata: rdata_q};
  assign up_profile_sel = sel_q;

endmodule

/* hdl/up_dac_channel_regs.sv */
// Per-channel DDS and pattern registers, one instance for each DAC channel
`timescale 1ns/100ps
`include "tpl_dac_params.svh"

module up_dac_channel_regs #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                       up_clk,
  input  logic                       up_rstn,
  input  tpl_dac_pkg::up_wr_req_t    up_wr,
  input  tpl_dac_pkg::up_rd_req_t    up_rd,
  output tpl_dac_pkg::up_rsp_t       up_rsp,
  output tpl_dac_pkg::dac_chan_cfg_t dac_chan_cfg
);

  import tpl_dac_pkg::*;

  logic wr_sel;
  logic rd_sel;
  dac_chan_cfg_t cfg_q;
  logic wack_q;
  logic rack_q;
  up_data_t rdata_q;
  up_data_t rd_word;

  // Region in bits 9..8, channel slot in bits 7..4
  assign wr_sel = up_wr.wreq && (up_wr.waddr[9:8] == 2'(`TPL_DAC_REGION_CHANNEL)) &&
                  (up_wr.waddr[7:4] == 4'(CHANNEL_ID));
  assign rd_sel = up_rd.rreq && (up_rd.raddr[9:8] == 2'(`TPL_DAC_REGION_CHANNEL)) &&
                  (up_rd.raddr[7:4] == 4'(CHANNEL_ID));

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      cfg_q <= '0;
    end else if (wr_sel) begin
      case (up_wr.waddr[3:0])
        4'h0: {cfg_q.dds_scale_1, cfg_q.dds_scale_0} <= up_wr.wdata;
        4'h1: {cfg_q.dds_incr_0, cfg_q.dds_init_0} <= up_wr.wdata;
        4'h2: {cfg_q.dds_incr_1, cfg_q.dds_init_1} <= up_wr.wdata;
        4'h3: {cfg_q.pat_data_1, cfg_q.pat_data_0} <= up_wr.wdata;
        4'h4: cfg_q.data_sel <= up_wr.wdata[3:0];
        default: cfg_q <= cfg_q;
      endcase
    end
  end

  // Read back mirrors the write layout
  always_comb begin
    case (up_rd.raddr[3:0])
      4'h0: rd_word = {cfg_q.dds_scale_1, cfg_q.dds_scale_0};
      4'h1: rd_word = {cfg_q.dds_incr_0, cfg_q.dds_init_0};
      4'h2: rd_word = {cfg_q.dds_incr_1, cfg_q.dds_init_1};
      4'h3: rd_word = {cfg_q.pat_data_1, cfg_q.pat_data_0};
      4'h4: rd_word = {28'd0, cfg_q.data_sel};
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      wack_q <= 1'b0;
      rack_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      wack_q <= wr_sel;
      rack_q <= rd_sel;
      rdata_q <= rd_sel ? rd_word : '0;
    end
  end

  assign up_rsp = '{wack: wack_q, rack: rack_q, rdata: rdata_q};
  assign dac_chan_cfg = cfg_q;

endmodule

/* hdl/up_dac_common_regs.sv */
// Common DAC registers: identification, scratch, data-path reset, sync, format and underflow
`timescale 1ns/100ps
`include "tpl_dac_params.svh"

module up_dac_common_regs (
  input  logic                    up_clk,
  input  logic                    up_rstn,
  input  tpl_dac_pkg::up_wr_req_t up_wr,
  input  tpl_dac_pkg::up_rd_req_t up_rd,
  input  logic                    dac_dunf,
  output tpl_dac_pkg::up_rsp_t    up_rsp,
  output logic                    dac_rst,
  output logic                    dac_sync,
  output logic                    dac_dds_format
);

  import tpl_dac_pkg::*;

  logic wr_sel;
  logic rd_sel;
  up_data_t scratch_q;
  logic resetn_q;
  logic sync_q;
  logic format_q;
  logic dunf_q;
  logic wack_q;
  logic rack_q;
  up_data_t rdata_q;
  up_data_t rd_word;

  assign wr_sel = up_wr.wreq && (up_wr.waddr[9:8] == 2'(`TPL_DAC_REGION_COMMON));
  assign rd_sel = up_rd.rreq && (up_rd.raddr[9:8] == 2'(`TPL_DAC_REGION_COMMON));

  // ******************************
  // Register writes
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      scratch_q <= '0;
      resetn_q <= 1'b0;
      sync_q <= 1'b0;
      format_q <= 1'b0;
      dunf_q <= 1'b0;
    end else begin
      sync_q <= wr_sel && (up_wr.waddr[7:0] == 8'h11) && up_wr.wdata[0];
      if (wr_sel && (up_wr.waddr[7:0] == 8'h02)) scratch_q <= up_wr.wdata;
      if (wr_sel && (up_wr.waddr[7:0] == 8'h10)) resetn_q <= up_wr.wdata[0];
      if (wr_sel && (up_wr.waddr[7:0] == 8'h11)) format_q <= up_wr.wdata[4];
      // Underflow is sticky, a new event beats the clear
      if (dac_dunf) begin
        dunf_q <= 1'b1;
      end else if (wr_sel && (up_wr.waddr[7:0] == 8'h12) && up_wr.wdata[0]) begin
        dunf_q <= 1'b0;
      end
    end
  end

  always_comb begin
    case (up_rd.raddr[7:0])
      8'h00: rd_word = `TPL_DAC_VERSION;
      8'h01: rd_word = `TPL_DAC_CORE_ID;
      8'h02: rd_word = scratch_q;
      8'h10: rd_word = {31'd0, resetn_q};
      8'h11: rd_word = {27'd0, format_q, 4'd0};
      8'h12: rd_word = {31'd0, dunf_q};
      8'h13: rd_word = 32'(`TPL_DAC_NUM_CHANNELS);
      default: rd_word = '0;
    endcase
  end

  // Ack one cycle after the request
  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      wack_q <= 1'b0;
      rack_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      wack_q <= wr_sel;
      rack_q <= rd_sel;
      rdata_q <= rd_sel ? rd_word : '0;
    end
  end

  assign up_rsp = '{wack: wack_q, rack: rack_q, rdata: rdata_q};
  assign dac_rst = ~resetn_q;
  assign dac_sync = sync_q;
  assign dac_dds_format = format_q;

endmodule

/* hdl/up_axi_slave.sv */
// AXI4-Lite slave that turns one transfer at a time into a single-cycle up-bus request
`timescale 1ns/100ps

module up_axi_slave (
  input  logic                    up_clk,
  input  logic                    up_rstn,
  input  tpl_dac_pkg::axil_req_t  s_axi,
  output tpl_dac_pkg::axil_rsp_t  s_axi_rsp,
  output tpl_dac_pkg::up_wr_req_t up_wr,
  output tpl_dac_pkg::up_rd_req_t up_rd,
  input  tpl_dac_pkg::up_rsp_t    up_rsp
);

  import tpl_dac_pkg::*;

  // Wait cycles before an unclaimed access is answered locally
  localparam int TIMEOUT = 16;

  axi_state_t state;
  logic [$clog2(TIMEOUT+1)-1:0] timeout_cnt;
  logic timeout;
  logic wr_hs;
  logic rd_hs;
  logic wreq_q;
  logic rreq_q;
  up_addr_t waddr_q;
  up_addr_t raddr_q;
  up_data_t wdata_q;
  up_data_t rdata_q;

  // Address and data channels are taken together; writes win over reads
  assign wr_hs = (state == idle) && s_axi.awvalid && s_axi.wvalid;
  assign rd_hs = (state == idle) && s_axi.arvalid && !(s_axi.awvalid && s_axi.wvalid);
  assign timeout = (timeout_cnt == TIMEOUT[$bits(timeout_cnt)-1:0]);

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      state <= idle;
      timeout_cnt <= '0;
      wreq_q <= 1'b0;
      rreq_q <= 1'b0;
    end else begin
      wreq_q <= wr_hs;
      rreq_q <= rd_hs;
      case (state)
        idle: begin
          timeout_cnt <= '0;
          if (wr_hs) begin
            state <= write_wait;
          end else if (rd_hs) begin
            state <= read_wait;
          end
        end
        write_wait: begin
          timeout_cnt <= timeout_cnt + 1'b1;
          if (up_rsp.wack || timeout) state <= write_resp;
        end
        write_resp: if (s_axi.bready) state <= idle;
        read_wait: begin
          timeout_cnt <= timeout_cnt + 1'b1;
          if (up_rsp.rack || timeout) state <= read_resp;
        end
        read_resp: if (s_axi.rready) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Byte address to word address, read data zero on timeout
  always_ff @(posedge up_clk) begin
    if (wr_hs) begin
      waddr_q <= s_axi.awaddr[11:2];
      wdata_q <= s_axi.wdata;
    end
    if (rd_hs) raddr_q <= s_axi.araddr[11:2];
    if (state == read_wait) begin
      if (up_rsp.rack) begin
        rdata_q <= up_rsp.rdata;
      end else if (timeout) begin
        rdata_q <= '0;
      end
    end
  end

  assign up_wr = '{wreq: wreq_q, waddr: waddr_q, wdata: wdata_q};
  assign up_rd = '{rreq: rreq_q, raddr: raddr_q};

  always_comb begin
    s_axi_rsp = '0;
    s_axi_rsp.awready = wr_hs;
    s_axi_rsp.wready = wr_hs;
    s_axi_rsp.bvalid = (state == write_resp);
    s_axi_rsp.arready = rd_hs;
    s_axi_rsp.rvalid = (state == read_resp);
    s_axi_rsp.rdata = rdata_q;
    // Always OKAY
    s_axi_rsp.bresp = 2'b00;
    s_axi_rsp.rresp = 2'b00;
  end

endmodule

/* hdl/tpl_dac_pkg.sv */
// Shared types of the DAC register map: up bus, AXI4-Lite, channel config and JESD profile
`include "tpl_dac_params.svh"

package tpl_dac_pkg;

  typedef logic [`TPL_DAC_UP_AW-1:0] up_addr_t;
  typedef logic [31:0] up_data_t;

  // Wide enough for one profile index, at least one bit
  typedef logic [$clog2((`TPL_DAC_NUM_PROFILES > 1) ? `TPL_DAC_NUM_PROFILES : 2)-1:0]
    profile_sel_t;

  // ******************************
  // Internal up bus
  typedef struct packed {
    logic     wreq;
    up_addr_t waddr;
    up_data_t wdata;
  } up_wr_req_t;

  typedef struct packed {
    logic     rreq;
    up_addr_t raddr;
  } up_rd_req_t;

  typedef struct packed {
    logic     wack;
    logic     rack;
    up_data_t rdata;
  } up_rsp_t;

  // ******************************
  // AXI4-Lite, master side then slave side
  typedef struct packed {
    logic        awvalid;
    logic [11:0] awaddr;
    logic        wvalid;
    up_data_t    wdata;
    logic [3:0]  wstrb;
    logic        bready;
    logic        arvalid;
    logic [11:0] araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    up_data_t   rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  // Per-channel DDS and pattern settings
  typedef struct packed {
    logic [15:0] dds_scale_0;
    logic [15:0] dds_init_0;
    logic [15:0] dds_incr_0;
    logic [15:0] dds_scale_1;
    logic [15:0] dds_init_1;
    logic [15:0] dds_incr_1;
    logic [15:0] pat_data_0;
    logic [15:0] pat_data_1;
    logic [3:0]  data_sel;
  } dac_chan_cfg_t;

  // Framer parameters of one JESD profile
  typedef struct packed {
    logic [7:0] m;
    logic [7:0] l;
    logic [7:0] s;
    logic [7:0] f;
    logic [7:0] n;
    logic [7:0] np;
  } jesd_params_t;

  typedef enum logic [2:0] {
    idle,
    write_wait,
    write_resp,
    read_wait,
    read_resp
  } axi_state_t;

endpackage

/* hdl/tpl_dac_params.svh */
// Build-time constants of the DAC register map, included by the package and the RTL blocks
`ifndef TPL_DAC_PARAMS_SVH
`define TPL_DAC_PARAMS_SVH

// Core sizing
`define TPL_DAC_NUM_CHANNELS 2
`define TPL_DAC_NUM_PROFILES 2
`define TPL_DAC_UP_AW 10

// Word-address bits 9..8 select a register block
`define TPL_DAC_REGION_COMMON 0
`define TPL_DAC_REGION_CHANNEL 1
`define TPL_DAC_REGION_TPL 2

// Identification
`define TPL_DAC_VERSION 32'h0001_0061
`define TPL_DAC_CORE_ID 32'h0000_0000

`endif
